//--- include/axi_ram_defs.svh
`ifndef AXI_RAM_DEFS_SVH
`define AXI_RAM_DEFS_SVH

// normal access response, the only code this slave returns
`define RESP_OKAY 2'b00

// data bytes per beat
// expands against AXI_DATA_W, so axi_ram_pkg must be in scope
`define BEAT_BYTES (AXI_DATA_W / 8)

`endif

//--- hw/axi_ram_pkg.sv
package axi_ram_pkg;
    `include "axi_ram_defs.svh"

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 16;              // byte address
    localparam int AXI_DATA_W = 32;
    localparam int LANES      = `BEAT_BYTES;     // one byte memory per lane
    localparam int LANE_OFS   = $clog2(LANES);   // byte offset bits within a word

    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2,
        BURST_RSVD  = 2'd3    // addressed like INCR
    } burst_e;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rd_state_e;

    // AW and AR share one request layout
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        burst_e                burst;
    } axi_addr_req_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [LANES-1:0]      strb;
        logic                  last;
    } axi_w_beat_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } axi_b_resp_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_beat_t;

    // write request fanned out to every byte lane
    typedef struct packed {
        logic [LANES-1:0]      en;
        logic [AXI_ADDR_W-1:0] word;    // word address, lanes keep the low bits
        logic [AXI_DATA_W-1:0] data;
    } lane_wr_t;

    function automatic logic [AXI_ADDR_W-1:0] next_beat_addr(
        input logic [AXI_ADDR_W-1:0] addr,
        input burst_e                burst,
        input logic [7:0]            len
    );
        logic [AXI_ADDR_W-1:0] incr;
        logic [AXI_ADDR_W-1:0] wrap_mask;
        incr      = (addr & ~AXI_ADDR_W'(`BEAT_BYTES - 1)) + AXI_ADDR_W'(`BEAT_BYTES);
        // wrap block is (len+1) beats, a power of two for legal WRAP lengths
        wrap_mask = (AXI_ADDR_W'(len) + AXI_ADDR_W'(1)) * AXI_ADDR_W'(`BEAT_BYTES)
                    - AXI_ADDR_W'(1);
        case (burst)
            BURST_FIXED: next_beat_addr = addr;
            BURST_WRAP:  next_beat_addr = (addr & ~wrap_mask) | (incr & wrap_mask);
            default:     next_beat_addr = incr;
        endcase
    endfunction

endpackage

//--- hw/ram_byte_lane.sv
`timescale 1ns/1ps

module ram_byte_lane #(
    parameter int MEM_AW = 10
) (
    input  logic              S_AXI_ACLK,
    input  logic              wr_en,
    input  logic [MEM_AW-1:0] wr_word,
    input  logic [7:0]        wr_byte,
    input  logic              rd_en,
    input  logic [MEM_AW-1:0] rd_word,
    output logic [7:0]        rd_byte
);
    logic [7:0] mem [2**MEM_AW];

    always_ff @(posedge S_AXI_ACLK) begin
        if (wr_en) begin
            mem[wr_word] <= wr_byte;
        end
    end

    // registered read port
    // a same-word write in the same cycle is not seen, old byte comes out
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_en) begin
            rd_byte <= mem[rd_word];
        end
    end

endmodule

//--- hw/axi_write_engine.sv
`timescale 1ns/1ps
`include "axi_ram_defs.svh"

module axi_write_engine
    import axi_ram_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic          S_AXI_ACLK,
    input  logic          S_AXI_ARESETN,
    input  axi_addr_req_t aw_req,
    input  logic          aw_valid,
    output logic          aw_ready,
    input  axi_w_beat_t   w_beat,
    input  logic          w_valid,
    output logic          w_ready,
    output logic          b_valid,
    output axi_b_resp_t   b_resp,
    input  logic          b_ready,
    output lane_wr_t      lane_wr
);
    wr_state_e             state;
    logic [AXI_ID_W-1:0]   burst_id;     // returned on B
    logic [AXI_ADDR_W-1:0] beat_addr;    // byte address of the current beat
    logic [7:0]            burst_len;    // only shapes WRAP bursts
    burst_e                burst_type;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;

    // handshake outputs come straight from the state
    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    // burst length is taken from wlast, not from awlen
                    if (w_fire && w_beat.last) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // burst context, loaded on AW and stepped per beat
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_fire) begin
            burst_id   <= aw_req.id;
            beat_addr  <= aw_req.addr;
            burst_len  <= aw_req.len;
            burst_type <= aw_req.burst;
        end else if (w_fire) begin
            beat_addr <= next_beat_addr(beat_addr, burst_type, burst_len);
        end
    end

    // lanes write at the edge that completes the W handshake
    always_comb begin
        lane_wr.en   = w_fire ? w_beat.strb : '0;
        // high address bits dropped, memory aliases over its size
        lane_wr.word = AXI_ADDR_W'(beat_addr[MEM_AW+LANE_OFS-1:LANE_OFS]);
        lane_wr.data = w_beat.data;
    end

    assign b_resp = '{id: burst_id, resp: `RESP_OKAY};

endmodule

//--- hw/axi_read_engine.sv
`timescale 1ns/1ps
`include "axi_ram_defs.svh"

module axi_read_engine
    import axi_ram_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    input  axi_addr_req_t         ar_req,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  logic                  r_ready,
    input  logic [AXI_DATA_W-1:0] lane_rdata,
    output logic                  rd_en,
    output logic [MEM_AW-1:0]     rd_word,
    output logic                  r_valid,
    output axi_r_beat_t           r_beat
);
    rd_state_e             state;
    logic [AXI_ID_W-1:0]   burst_id;
    logic [AXI_ADDR_W-1:0] beat_addr;     // address of the beat being presented
    logic [AXI_ADDR_W-1:0] next_addr;
    logic [AXI_ADDR_W-1:0] fetch_addr;    // address the lanes read this cycle
    logic [7:0]            burst_len;
    burst_e                burst_type;
    logic [7:0]            beat_cnt;      // beats already handed over
    logic                  last_beat;
    logic                  ar_fire;
    logic                  r_fire;

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_SEND);

    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign last_beat = (beat_cnt == burst_len);

    assign next_addr  = next_beat_addr(beat_addr, burst_type, burst_len);
    assign fetch_addr = (state == RD_IDLE) ? ar_req.addr : next_addr;

    // one lane read per beat; the lanes hold their byte otherwise,
    // which keeps rdata steady while rready is low
    assign rd_en   = ar_fire || (r_fire && !last_beat);
    assign rd_word = fetch_addr[MEM_AW+LANE_OFS-1:LANE_OFS];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state    <= RD_FETCH;
                        beat_cnt <= '0;
                    end
                end
                RD_FETCH: begin
                    state <= RD_SEND;    // lane data settles during this cycle
                end
                RD_SEND: begin
                    if (r_fire) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        state    <= last_beat ? RD_IDLE : RD_FETCH;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // burst context
    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire) begin
            burst_id   <= ar_req.id;
            beat_addr  <= ar_req.addr;
            burst_len  <= ar_req.len;
            burst_type <= ar_req.burst;
        end else if (r_fire && !last_beat) begin
            beat_addr <= next_addr;    // same address the lanes just fetched
        end
    end

    always_comb begin
        r_beat.id   = burst_id;
        r_beat.data = lane_rdata;    // straight from the lane registers
        r_beat.resp = `RESP_OKAY;
        r_beat.last = last_beat;
    end

endmodule

//--- hw/axi_ram_top.sv
`timescale 1ns/1ps

module axi_ram_top
    import axi_ram_pkg::*;
#(
    parameter int MEM_AW = 10    // word address bits of each lane
) (
    input  logic                  S_AXI_ACLK,
    input  logic                  S_AXI_ARESETN,
    // write address
    input  logic [AXI_ID_W-1:0]   s_axi_awid,
    input  logic [AXI_ADDR_W-1:0] s_axi_awaddr,
    input  logic [7:0]            s_axi_awlen,
    input  logic [1:0]            s_axi_awburst,
    input  logic                  s_axi_awvalid,
    output logic                  s_axi_awready,
    // write data
    input  logic [AXI_DATA_W-1:0] s_axi_wdata,
    input  logic [LANES-1:0]      s_axi_wstrb,
    input  logic                  s_axi_wlast,
    input  logic                  s_axi_wvalid,
    output logic                  s_axi_wready,
    // write response
    output logic [AXI_ID_W-1:0]   s_axi_bid,
    output logic [1:0]            s_axi_bresp,
    output logic                  s_axi_bvalid,
    input  logic                  s_axi_bready,
    // read address
    input  logic [AXI_ID_W-1:0]   s_axi_arid,
    input  logic [AXI_ADDR_W-1:0] s_axi_araddr,
    input  logic [7:0]            s_axi_arlen,
    input  logic [1:0]            s_axi_arburst,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    // read data
    output logic [AXI_ID_W-1:0]   s_axi_rid,
    output logic [AXI_DATA_W-1:0] s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rlast,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready
);
    axi_addr_req_t         aw_req;
    axi_addr_req_t         ar_req;
    axi_w_beat_t           w_beat;
    axi_b_resp_t           b_resp;
    axi_r_beat_t           r_beat;
    lane_wr_t              lane_wr;
    logic                  rd_en;
    logic [MEM_AW-1:0]     rd_word;
    logic [AXI_DATA_W-1:0] lane_rdata;    // gathered lane outputs

    assign aw_req = '{id: s_axi_awid, addr: s_axi_awaddr, len: s_axi_awlen,
                      burst: burst_e'(s_axi_awburst)};
    assign ar_req = '{id: s_axi_arid, addr: s_axi_araddr, len: s_axi_arlen,
                      burst: burst_e'(s_axi_arburst)};
    assign w_beat = '{data: s_axi_wdata, strb: s_axi_wstrb, last: s_axi_wlast};

    assign s_axi_bid   = b_resp.id;
    assign s_axi_bresp = b_resp.resp;
    assign s_axi_rid   = r_beat.id;
    assign s_axi_rdata = r_beat.data;
    assign s_axi_rresp = r_beat.resp;
    assign s_axi_rlast = r_beat.last;

    axi_write_engine #(.MEM_AW(MEM_AW)) wr_engine_inst (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .aw_req       (aw_req),
        .aw_valid     (s_axi_awvalid),
        .aw_ready     (s_axi_awready),
        .w_beat       (w_beat),
        .w_valid      (s_axi_wvalid),
        .w_ready      (s_axi_wready),
        .b_valid      (s_axi_bvalid),
        .b_resp       (b_resp),
        .b_ready      (s_axi_bready),
        .lane_wr      (lane_wr)
    );

    axi_read_engine #(.MEM_AW(MEM_AW)) rd_engine_inst (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .ar_req       (ar_req),
        .ar_valid     (s_axi_arvalid),
        .ar_ready     (s_axi_arready),
        .r_ready      (s_axi_rready),
        .lane_rdata   (lane_rdata),
        .rd_en        (rd_en),
        .rd_word      (rd_word),
        .r_valid      (s_axi_rvalid),
        .r_beat       (r_beat)
    );

    // one byte-wide memory per strobe bit
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        ram_byte_lane #(.MEM_AW(MEM_AW)) lane_inst (
            .S_AXI_ACLK(S_AXI_ACLK),
            .wr_en     (lane_wr.en[i]),
            .wr_word   (lane_wr.word[MEM_AW-1:0]),
            .wr_byte   (lane_wr.data[8*i +: 8]),
            .rd_en     (rd_en),
            .rd_word   (rd_word),
            .rd_byte   (lane_rdata[8*i +: 8])
        );
    end

endmodule

//--- verification/axi_ram_assertions.sv
`timescale 1ns/1ps

module axi_ram_assertions
    import axi_ram_pkg::*;
(
    input logic                  S_AXI_ACLK,
    input logic                  S_AXI_ARESETN,
    input logic                  s_axi_awvalid,
    input logic                  s_axi_awready,
    input logic                  s_axi_bvalid,
    input logic                  s_axi_bready,
    input logic [AXI_ID_W-1:0]   s_axi_bid,
    input logic                  s_axi_rvalid,
    input logic                  s_axi_rready,
    input logic [AXI_ID_W-1:0]   s_axi_rid,
    input logic [AXI_DATA_W-1:0] s_axi_rdata,
    input logic                  s_axi_rlast
);
    logic write_open;    // between AW and B handshakes

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            write_open <= 1'b0;
        end else if (s_axi_bvalid && s_axi_bready) begin
            write_open <= 1'b0;
        end else if (s_axi_awvalid && s_axi_awready) begin
            write_open <= 1'b1;
        end
    end

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bid))
        else $error("B channel changed while bready low");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
            && $stable(s_axi_rlast) && $stable(s_axi_rid))
        else $error("R channel changed while rready low");

    assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        write_open |-> !s_axi_awready)
        else $error("awready high during an open write burst");

endmodule

bind axi_ram_top axi_ram_assertions assertions_inst (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_bvalid (s_axi_bvalid),
    .s_axi_bready (s_axi_bready),
    .s_axi_bid    (s_axi_bid),
    .s_axi_rvalid (s_axi_rvalid),
    .s_axi_rready (s_axi_rready),
    .s_axi_rid    (s_axi_rid),
    .s_axi_rdata  (s_axi_rdata),
    .s_axi_rlast  (s_axi_rlast)
);

//--- verification/axi_ram_tb.sv
`timescale 1ns/1ps
`include "axi_ram_defs.svh"

module axi_ram_tb
    import axi_ram_pkg::*;
;
    localparam int MEM_AW    = 10;
    localparam int MEM_BYTES = 4096;
    localparam int TIMEOUT   = 100;    // cycles per wait loop

    logic                  S_AXI_ACLK;
    logic                  S_AXI_ARESETN;
    logic [AXI_ID_W-1:0]   awid, arid, bid, rid;
    logic [AXI_ADDR_W-1:0] awaddr, araddr;
    logic [7:0]            awlen, arlen;
    logic [1:0]            awburst, arburst, bresp, rresp;
    logic                  awvalid, awready, wvalid, wready, wlast;
    logic                  bvalid, bready, arvalid, arready, rvalid, rready, rlast;
    logic [AXI_DATA_W-1:0] wdata, rdata;
    logic [LANES-1:0]      wstrb;

    logic [7:0] model [MEM_BYTES];
    int         seed;
    bit         bp_mode;     // random bready/rready
    bit         lat_mode;    // check read beat spacing

    always #4 S_AXI_ACLK = ~S_AXI_ACLK;

    axi_ram_top #(.MEM_AW(MEM_AW)) axi_ram_top_inst (
        .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
        .s_axi_awid(awid), .s_axi_awaddr(awaddr), .s_axi_awlen(awlen),
        .s_axi_awburst(awburst), .s_axi_awvalid(awvalid), .s_axi_awready(awready),
        .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wlast(wlast),
        .s_axi_wvalid(wvalid), .s_axi_wready(wready),
        .s_axi_bid(bid), .s_axi_bresp(bresp), .s_axi_bvalid(bvalid), .s_axi_bready(bready),
        .s_axi_arid(arid), .s_axi_araddr(araddr), .s_axi_arlen(arlen),
        .s_axi_arburst(arburst), .s_axi_arvalid(arvalid), .s_axi_arready(arready),
        .s_axi_rid(rid), .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rlast(rlast),
        .s_axi_rvalid(rvalid), .s_axi_rready(rready)
    );

    task automatic stop_sim();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s actual 0x%h expected 0x%h", name, actual, expected);
            stop_sim();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        stop_sim();
    endtask

    function automatic logic [31:0] random_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return r % n;
    endfunction

    function automatic logic pick_ready();
        logic [31:0] r;
        r = $random(seed);
        return bp_mode ? r[0] : 1'b1;
    endfunction

    function automatic logic [31:0] model_word(input logic [15:0] a);
        return {model[{a[11:2], 2'd3}], model[{a[11:2], 2'd2}],
                model[{a[11:2], 2'd1}], model[{a[11:2], 2'd0}]};
    endfunction

    // expected next beat address for 4-byte beats
    function automatic logic [15:0] step_addr(input logic [15:0] a, input logic [1:0] burst,
                                             input logic [7:0] len);
        logic [15:0] aligned;
        logic [15:0] block;    // wrap block size in bytes
        logic [15:0] step;
        aligned = {a[15:2], 2'b00};
        block   = (16'(len) + 16'd1) * 16'd4;
        case (burst)
            2'd0: step = a;
            2'd2: begin
                if ((aligned % block) + 16'd4 == block) begin
                    step = aligned - (aligned % block);    // back to block start
                end else begin
                    step = aligned + 16'd4;
                end
            end
            default: step = aligned + 16'd4;
        endcase
        return step;
    endfunction

    task automatic write_burst(input logic [3:0] id, input logic [15:0] addr,
                               input logic [7:0] len, input logic [1:0] burst,
                               input bit full_strb);
        logic [15:0] a;
        logic [31:0] data;
        logic [31:0] r;
        int          cnt;
        @(posedge S_AXI_ACLK);
        awid    <= id;
        awaddr  <= addr;
        awlen   <= len;
        awburst <= burst;
        awvalid <= 1'b1;
        cnt = 0;
        do begin
            @(negedge S_AXI_ACLK);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("awready");
        end while (!awready);
        @(posedge S_AXI_ACLK);    // AW handshake edge
        awvalid <= 1'b0;
        a = addr;
        for (int beat = 0; beat <= int'(len); beat++) begin
            data = $random(seed);
            r    = $random(seed);
            wdata  <= data;
            wstrb  <= full_strb ? 4'hf : r[3:0];
            wlast  <= (beat == int'(len));
            wvalid <= 1'b1;
            cnt = 0;
            do begin
                @(negedge S_AXI_ACLK);
                cnt++;
                if (cnt > TIMEOUT) report_timeout("wready");
            end while (!wready);
            @(posedge S_AXI_ACLK);    // bytes land at this edge
            for (int lane = 0; lane < LANES; lane++) begin
                if (full_strb || r[lane]) model[{a[11:2], 2'(lane)}] = data[8*lane +: 8];
            end
            a = step_addr(a, burst, len);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        bready <= pick_ready();
        cnt = 0;
        forever begin
            @(negedge S_AXI_ACLK);
            if (bvalid && bready) break;
            cnt++;
            if (cnt > TIMEOUT) report_timeout("write response");
            @(posedge S_AXI_ACLK);
            bready <= pick_ready();
        end
        check_value("bid", 32'(bid), 32'(id));
        check_value("bresp", 32'(bresp), 32'(`RESP_OKAY));
        @(posedge S_AXI_ACLK);
        bready <= 1'b0;
        @(negedge S_AXI_ACLK);
        check_value("bvalid after B handshake", 32'(bvalid), 32'd0);
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [15:0] addr,
                              input logic [7:0] len, input logic [1:0] burst);
        logic [15:0] a;
        int          beat;
        int          gap;
        int          cnt;
        @(posedge S_AXI_ACLK);
        arid    <= id;
        araddr  <= addr;
        arlen   <= len;
        arburst <= burst;
        arvalid <= 1'b1;
        cnt = 0;
        do begin
            @(negedge S_AXI_ACLK);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("arready");
        end while (!arready);
        @(posedge S_AXI_ACLK);
        arvalid <= 1'b0;
        rready  <= pick_ready();
        a    = addr;
        beat = 0;
        gap  = 0;
        cnt  = 0;
        while (beat <= int'(len)) begin
            @(negedge S_AXI_ACLK);
            gap++;
            cnt++;
            if (cnt > TIMEOUT) report_timeout("read beat");
            if (rvalid && rready) begin
                check_value("rdata", rdata, model_word(a));
                check_value("rid", 32'(rid), 32'(id));
                check_value("rresp", 32'(rresp), 32'(`RESP_OKAY));
                check_value("rlast", 32'(rlast), 32'(beat == int'(len)));
                if (lat_mode) check_value("rvalid delay", gap, 2);
                a = step_addr(a, burst, len);
                beat++;
                gap = 0;
                cnt = 0;
            end
            @(posedge S_AXI_ACLK);
            rready <= (beat <= int'(len)) ? pick_ready() : 1'b0;
        end
        @(negedge S_AXI_ACLK);
        check_value("rvalid after last beat", 32'(rvalid), 32'd0);
    endtask

    // random type, length, address and strobes, then a random read
    task automatic random_traffic(input int count);
        logic [31:0] r;
        logic [1:0]  t;
        logic [7:0]  len;
        logic [15:0] a;
        for (int n = 0; n < count; n++) begin
            for (int dir = 0; dir < 2; dir++) begin
                r   = $random(seed);
                t   = r[1:0];
                len = (t == 2'd2) ? 8'((2 << r[3:2]) - 1) : {4'd0, r[7:4]};
                a   = (t == 2'd2) ? {r[23:10], 2'b00} : r[31:16];
                if (dir == 0) write_burst(r[11:8], a, len, t, 1'b0);
                else read_burst(r[11:8], a, len, t);
            end
        end
    endtask

    initial begin
        int          addr;
        int          len;
        logic [31:0] r;
        seed = 32'h7789_c4e7;
        S_AXI_ACLK = 1'b0;
        S_AXI_ARESETN = 1'b0;
        {awid, awaddr, awlen, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arburst, arvalid, rready} = '0;
        bp_mode  = 1'b0;
        lat_mode = 1'b0;
        repeat (16) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(negedge S_AXI_ACLK);
        check_value("awready", 32'(awready), 32'd1);
        check_value("arready", 32'(arready), 32'd1);
        check_value("bvalid", 32'(bvalid), 32'd0);
        check_value("rvalid", 32'(rvalid), 32'd0);

        // fill the whole memory, then read it back
        for (int pass = 0; pass < 2; pass++) begin
            addr = 0;
            while (addr < MEM_BYTES) begin
                len = int'(random_below(16));
                if (addr / 4 + len + 1 > MEM_BYTES / 4) len = MEM_BYTES / 4 - addr / 4 - 1;
                r = $random(seed);
                if (pass == 0) write_burst(r[3:0], 16'(addr), 8'(len), 2'd1, 1'b1);
                else read_burst(r[3:0], 16'(addr), 8'(len), 2'd1);
                addr += (len + 1) * 4;
            end
        end

        random_traffic(40);
        bp_mode = 1'b1;    // back-pressure on B and R
        random_traffic(40);

        bp_mode  = 1'b0;
        lat_mode = 1'b1;
        for (int n = 0; n < 4; n++) begin
            r = $random(seed);
            read_burst(r[3:0], r[31:16], {4'd0, r[7:4]}, 2'd1);
        end
        lat_mode = 1'b0;

        // concurrent write and read on disjoint address ranges
        bp_mode = 1'b1;
        for (int n = 0; n < 6; n++) begin
            r = $random(seed);
            fork
                write_burst(r[3:0], {7'd0, r[8:2], 2'b00}, {4'd0, r[15:12]}, 2'd1, 1'b0);
                read_burst(r[7:4], {5'd0, 1'b1, r[25:18], 2'b00}, {4'd0, r[31:28]}, 2'd1);
            join
            read_burst(r[3:0], {7'd0, r[8:2], 2'b00}, {4'd0, r[15:12]}, 2'd1);
        end

        repeat (4) @(posedge S_AXI_ACLK);
        $display("sim passed");
        $finish;
    end

endmodule

//--- axi_ram.f
+incdir+include
hw/axi_ram_pkg.sv
hw/ram_byte_lane.sv
hw/axi_write_engine.sv
hw/axi_read_engine.sv
hw/axi_ram_top.sv
verification/axi_ram_assertions.sv
verification/axi_ram_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the AXI RAM testbench with Verilator, runs it, and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f axi_ram.f --top-module axi_ram_tb -o Vaxi_ram_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vaxi_ram_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
